// File: nibble_core.f
hw/mem_pkg.sv
hw/cpu_types_pkg.sv
hw/data_bus_if.sv
hw/microcycle_ctrl.sv
hw/cpu_regs.sv
hw/nibble_ram.sv
hw/nibble_core_top.sv
test/nibble_core_chk.sv
test/nibble_core_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the nibble core testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert \
    -f nibble_core.f \
    --top-module nibble_core_tb \
    -Mdir obj_dir -o nibble_core_sim; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/nibble_core_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "All checks passed" "$LOG"; then
  exit 0
fi

echo "Pass message not found in $LOG"
exit 1

// File: test/nibble_core_tb.sv
`default_nettype none

module nibble_core_tb
  import cpu_types_pkg::*;
#(
  parameter int WAIT_STATES = 1
);

  timeunit 1ns;
  timeprecision 1ps;

  localparam int TIMEOUT = 20 * (WAIT_STATES + 2);

  logic        clk;
  logic        arst_n;
  logic        start;
  reg_type     src;
  reg_type     dst;
  reg_inc_type inc;
  logic [3:0]  immed;
  logic [3:0]  alu;
  logic        busy;
  logic        done;
  logic [3:0]  xfer_data;

  // Reference model state
  logic [3:0]  m_a, m_b, m_ta, m_tb;
  logic [11:0] m_x, m_y;
  logic [7:0]  m_sp;
  logic [3:0]  m_mem [0:4095];
  bit          m_valid [0:4095];

  logic [3:0]  exp_q [$];
  string       name_q [$];
  string       cur_test;
  string       chk_name;
  logic [3:0]  chk_exp;
  logic [31:0] lcg_state;
  int          errors;
  int          checks;
  int          accepted;
  int          done_count;
  bit          timed_out;

  nibble_core_top #(
    .WAIT_STATES (WAIT_STATES)
  ) i_nibble_core_top (
    .clk       (clk),
    .arst_n    (arst_n),
    .start     (start),
    .src       (src),
    .dst       (dst),
    .inc       (inc),
    .immed     (immed),
    .alu       (alu),
    .busy      (busy),
    .done      (done),
    .xfer_data (xfer_data)
  );

  always #5 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return {17'd0, lcg_state[30:16]};
  endfunction

  function automatic bit mem_operand(reg_type loc);
    return (loc == REG_MX) || (loc == REG_MY) || (loc == REG_MSP) || (loc == REG_MN);
  endfunction

  function automatic logic [11:0] ref_addr(reg_type loc, logic [3:0] im);
    case (loc)
      REG_MX:  return m_x;
      REG_MY:  return m_y;
      REG_MSP: return {4'h0, m_sp};
      default: return {8'h00, im};
    endcase
  endfunction

  // ------------------------------------------------------------------------
  // Reference model: returns the moved nibble and updates the model
  // ------------------------------------------------------------------------
  function automatic logic [3:0] ref_xfer(reg_type s, reg_type d, reg_inc_type i,
                                          logic [3:0] im, logic [3:0] al);
    logic [3:0] v;
    case (s)
      REG_A:     v = m_a;
      REG_B:     v = m_b;
      REG_TEMPA: v = m_ta;
      REG_TEMPB: v = m_tb;
      REG_XL:    v = m_x[3:0];
      REG_XH:    v = m_x[7:4];
      REG_XP:    v = m_x[11:8];
      REG_YL:    v = m_y[3:0];
      REG_YH:    v = m_y[7:4];
      REG_YP:    v = m_y[11:8];
      REG_SPL:   v = m_sp[3:0];
      REG_SPH:   v = m_sp[7:4];
      REG_IMM:   v = im;
      REG_ALU:   v = al;
      default:   v = m_mem[ref_addr(s, im)];
    endcase
    case (d)
      REG_A:     m_a = v;
      REG_B:     m_b = v;
      REG_TEMPA: m_ta = v;
      REG_TEMPB: m_tb = v;
      REG_XL:    m_x[3:0] = v;
      REG_XH:    m_x[7:4] = v;
      REG_XP:    m_x[11:8] = v;
      REG_YL:    m_y[3:0] = v;
      REG_YH:    m_y[7:4] = v;
      REG_YP:    m_y[11:8] = v;
      REG_SPL:   m_sp[3:0] = v;
      REG_SPH:   m_sp[7:4] = v;
      REG_MX, REG_MY, REG_MSP, REG_MN: begin
        m_mem[ref_addr(d, im)]   = v;
        m_valid[ref_addr(d, im)] = 1'b1;
      end
      default: ;
    endcase
    // Pointer increment wraps inside the page
    case (i)
      REG_XHL: m_x = {m_x[11:8], m_x[7:0] + 8'd1};
      REG_YHL: m_y = {m_y[11:8], m_y[7:0] + 8'd1};
      REG_SP:  m_sp = m_sp + 8'd1;
      default: ;
    endcase
    return v;
  endfunction

  task automatic issue(reg_type s, reg_type d, reg_inc_type i,
                       logic [3:0] im, logic [3:0] al);
    @(posedge clk);
    src   <= s;
    dst   <= d;
    inc   <= i;
    immed <= im;
    alu   <= al;
    start <= 1'b1;
    exp_q.push_back(ref_xfer(s, d, i, im, al));
    name_q.push_back(cur_test);
    accepted++;
    @(posedge clk);
    start <= 1'b0;
  endtask

  task automatic wait_done(output int cycles);
    int  n;
    bit  got;
    n   = 0;
    got = 1'b0;
    while (!got && n < TIMEOUT) begin
      @(negedge clk);
      n++;
      got = done;
    end
    cycles = n;
    if (!got) begin
      timed_out = 1'b1;
      errors++;
      $display("Timeout: no done within %0d cycles in test %s", TIMEOUT, cur_test);
    end
  endtask

  task automatic move(reg_type s, reg_type d, reg_inc_type i,
                      logic [3:0] im, logic [3:0] al);
    int lat;
    if (timed_out) begin
      return;
    end
    issue(s, d, i, im, al);
    wait_done(lat);
    if (!timed_out && !mem_operand(s) && !mem_operand(d)) begin
      checks++;
      if (lat != 3) begin
        errors++;
        $display("FAILED %s latency expected 3 actual %0d", cur_test, lat);
      end
    end
  endtask

  // Compare every done against the model
  always @(negedge clk) begin
    if (arst_n && done) begin
      done_count++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("A done pulse arrived with no transfer pending");
      end else begin
        chk_exp  = exp_q.pop_front();
        chk_name = name_q.pop_front();
        checks++;
        if (xfer_data !== chk_exp) begin
          errors++;
          $display("FAILED %s expected %h actual %h", chk_name, chk_exp, xfer_data);
        end
      end
    end
  end

  initial begin
    reg_type     r_src;
    reg_type     r_dst;
    logic [31:0] r;
    logic [3:0]  r_im;
    int          k;
    clk = 1'b0;
    arst_n = 1'b0;
    start = 1'b0;
    src = REG_A;
    dst = REG_A;
    inc = REG_NONE;
    immed = 4'h0;
    alu = 4'h0;
    {m_a, m_b, m_ta, m_tb, m_x, m_y, m_sp} = '0;
    for (k = 0; k < 4096; k++) begin
      m_valid[k] = 1'b0;
    end
    lcg_state = 32'd12210;
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;

    cur_test = "reset";
    @(negedge clk);
    checks++;
    if (busy || done) begin
      errors++;
      $display("busy or done is high right after reset");
    end
    move(REG_A, REG_A, REG_NONE, 4'h0, 4'h0);

    cur_test = "imm_load";
    for (k = 0; k < 12; k++) begin
      move(REG_IMM, reg_type'(k[4:0]), REG_NONE, 4'(k + 3), 4'h0);
      move(reg_type'(k[4:0]), REG_TEMPA, REG_NONE, 4'h0, 4'h0);
    end

    cur_test = "mem_access";
    move(REG_IMM, REG_XP, REG_NONE, 4'h2, 4'h0);
    move(REG_ALU, REG_XH, REG_NONE, 4'h0, 4'h5);
    move(REG_IMM, REG_XL, REG_NONE, 4'h3, 4'h0);
    move(REG_IMM, REG_MX, REG_NONE, 4'hA, 4'h0);
    move(REG_MX, REG_A, REG_NONE, 4'h0, 4'h0);
    move(REG_IMM, REG_YP, REG_NONE, 4'h7, 4'h0);
    move(REG_ALU, REG_YH, REG_NONE, 4'h0, 4'hC);
    move(REG_ALU, REG_YL, REG_NONE, 4'h0, 4'h1);
    move(REG_IMM, REG_MY, REG_NONE, 4'h6, 4'h0);
    move(REG_MY, REG_B, REG_NONE, 4'h0, 4'h0);
    move(REG_ALU, REG_SPH, REG_NONE, 4'h0, 4'h3);
    move(REG_IMM, REG_SPL, REG_NONE, 4'hE, 4'h0);
    move(REG_ALU, REG_MSP, REG_NONE, 4'h0, 4'h9);
    move(REG_MSP, REG_TEMPB, REG_NONE, 4'h0, 4'h0);
    move(REG_B, REG_MN, REG_NONE, 4'h9, 4'h0);
    move(REG_MN, REG_A, REG_NONE, 4'h9, 4'h0);

    cur_test = "post_inc";
    move(REG_IMM, REG_XH, REG_NONE, 4'hF, 4'h0);
    move(REG_IMM, REG_XL, REG_NONE, 4'hF, 4'h0);
    move(REG_IMM, REG_MX, REG_XHL, 4'h4, 4'h0);
    move(REG_IMM, REG_MX, REG_NONE, 4'hD, 4'h0);
    move(REG_XL, REG_A, REG_NONE, 4'h0, 4'h0);
    move(REG_XH, REG_A, REG_NONE, 4'h0, 4'h0);
    move(REG_XP, REG_A, REG_NONE, 4'h0, 4'h0);
    move(REG_IMM, REG_XH, REG_NONE, 4'hF, 4'h0);
    move(REG_IMM, REG_XL, REG_NONE, 4'hF, 4'h0);
    move(REG_MX, REG_B, REG_XHL, 4'h0, 4'h0);
    move(REG_MX, REG_B, REG_NONE, 4'h0, 4'h0);
    // Y steps from 0x7C0 onto the nibble stored at 0x7C1
    move(REG_IMM, REG_YL, REG_NONE, 4'h0, 4'h0);
    move(REG_IMM, REG_MY, REG_YHL, 4'h8, 4'h0);
    move(REG_MY, REG_A, REG_NONE, 4'h0, 4'h0);
    move(REG_ALU, REG_MN, REG_NONE, 4'h0, 4'hB);
    move(REG_IMM, REG_SPH, REG_NONE, 4'hF, 4'h0);
    move(REG_IMM, REG_SPL, REG_NONE, 4'hF, 4'h0);
    move(REG_IMM, REG_MSP, REG_SP, 4'h1, 4'h0);
    move(REG_SPL, REG_A, REG_NONE, 4'h0, 4'h0);
    move(REG_MSP, REG_A, REG_NONE, 4'h0, 4'h0);

    cur_test = "random";
    for (k = 0; k < 80; k++) begin
      r     = lcg_next();
      r_im  = r[3:0];
      r_src = reg_type'(5'(r[13:4] % 18));
      r     = lcg_next();
      r_dst = reg_type'(5'(r[13:4] % 18));
      // Unwritten memory has no defined value
      if (mem_operand(r_src) && !m_valid[ref_addr(r_src, r_im)]) begin
        r_src = REG_IMM;
      end
      move(r_src, r_dst, reg_inc_type'(r[1:0]), r_im, r[7:4]);
    end

    cur_test = "busy_start";
    if (!timed_out) begin
      issue(REG_MN, REG_TEMPA, REG_NONE, 4'h9, 4'h0);
      start <= 1'b1;
      dst   <= REG_A;
      @(posedge clk);
      @(posedge clk);
      start <= 1'b0;
      wait_done(k);
      repeat (TIMEOUT) @(posedge clk);
      checks++;
      if (done_count != accepted) begin
        errors++;
        $display("FAILED %s expected %0d actual %0d", cur_test, accepted, done_count);
      end
    end

    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: test/nibble_core_chk.sv
`default_nettype none

module nibble_core_chk
  import mem_pkg::*;
(
  input wire              clk,
  input wire              arst_n,
  input wire              stb,
  input wire              we,
  input wire              ack,
  input wire [ADDR_W-1:0] adr
);

  timeunit 1ns;
  timeprecision 1ps;

  // Ack only answers a strobe
  a_ack_with_stb: assert property (@(posedge clk) disable iff (!arst_n) ack |-> stb)
    else $error("ack high without stb");

  // Ack is a single pulse and the master lets go of the strobe after it
  a_ack_single: assert property (@(posedge clk) disable iff (!arst_n)
    ack |=> (!ack && !stb))
    else $error("ack or stb still high in the cycle after ack");

  // Request is frozen until the slave answers
  a_req_stable: assert property (@(posedge clk) disable iff (!arst_n)
    (stb && !ack) |=> ($stable(adr) && $stable(we)))
    else $error("adr or we changed while waiting for ack");

endmodule

bind nibble_ram nibble_core_chk i_nibble_core_chk (
  .clk    (clk),
  .arst_n (arst_n),
  .stb    (bus.stb),
  .we     (bus.we),
  .ack    (bus.ack),
  .adr    (bus.adr)
);

`default_nettype wire

// File: hw/nibble_core_top.sv
`default_nettype none

module nibble_core_top
  import cpu_types_pkg::*;
#(
  parameter int WAIT_STATES = 1
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        start,
  input  reg_type     src,
  input  reg_type     dst,
  input  reg_inc_type inc,
  input  logic [3:0]  immed,
  input  logic [3:0]  alu,
  output logic        busy,
  output logic        done,
  output logic [3:0]  xfer_data
);

  microcode_cycle cycle;
  logic           capture;
  logic           src_mem;
  logic           dst_mem;
  logic           mem_done;

  data_bus_if bus_if ();

  // Start only counts while idle
  assign capture = start && !busy;

  microcycle_ctrl i_microcycle_ctrl (
    .clk      (clk),
    .arst_n   (arst_n),
    .start    (start),
    .src_mem  (src_mem),
    .dst_mem  (dst_mem),
    .mem_done (mem_done),
    .cycle    (cycle),
    .busy     (busy),
    .done     (done)
  );

  cpu_regs i_cpu_regs (
    .clk       (clk),
    .arst_n    (arst_n),
    .cycle     (cycle),
    .capture   (capture),
    .src       (src),
    .dst       (dst),
    .inc       (inc),
    .immed     (immed),
    .alu       (alu),
    .mem_done  (mem_done),
    .xfer_data (xfer_data),
    .src_mem   (src_mem),
    .dst_mem   (dst_mem),
    .bus       (bus_if.master)
  );

  nibble_ram #(
    .WAIT_STATES (WAIT_STATES)
  ) i_nibble_ram (
    .clk    (clk),
    .arst_n (arst_n),
    .bus    (bus_if.slave)
  );

endmodule

`default_nettype wire

// File: hw/nibble_ram.sv
`default_nettype none

module nibble_ram
  import mem_pkg::*;
#(
  parameter int WAIT_STATES = 1
) (
  input  logic      clk,
  input  logic      arst_n,
  data_bus_if.slave bus
);

  localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  logic [NIBBLE_W-1:0] mem [0:(1 << ADDR_W) - 1];
  logic [CNT_W-1:0]    wait_cnt;
  logic                req;
  logic                ack_next;

  assign req      = bus.cyc && bus.stb && !bus.ack;
  assign ack_next = req && (wait_cnt == CNT_W'(WAIT_STATES));

  // ---------------------------------------------------------------------------
  // Wait counter and ack
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wait_cnt <= '0;
      bus.ack  <= 1'b0;
    end else begin
      bus.ack <= ack_next;
      if (!req || ack_next) begin
        wait_cnt <= '0;
      end else begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end
  end

  // Read data lands together with ack
  always_ff @(posedge clk) begin
    if (ack_next) begin
      bus.dat_r <= mem[bus.adr];
    end
    if (bus.ack && bus.stb && bus.we) begin
      mem[bus.adr] <= bus.dat_w;
    end
  end

endmodule

`default_nettype wire

// File: hw/cpu_regs.sv
`default_nettype none

module cpu_regs
  import cpu_types_pkg::*;
  import mem_pkg::*;
(
  input  logic                clk,
  input  logic                arst_n,
  input  microcode_cycle      cycle,
  input  logic                capture,
  input  reg_type             src,
  input  reg_type             dst,
  input  reg_inc_type         inc,
  input  logic [NIBBLE_W-1:0] immed,
  input  logic [NIBBLE_W-1:0] alu,
  output logic                mem_done,
  output logic [NIBBLE_W-1:0] xfer_data,
  output logic                src_mem,
  output logic                dst_mem,
  data_bus_if.master          bus
);

  reg_type             src_q;
  reg_type             dst_q;
  reg_inc_type         inc_q;
  logic [NIBBLE_W-1:0] immed_q;
  logic [NIBBLE_W-1:0] alu_q;

  logic [NIBBLE_W-1:0] a;
  logic [NIBBLE_W-1:0] b;
  logic [NIBBLE_W-1:0] temp_a;
  logic [NIBBLE_W-1:0] temp_b;
  addr_word_u          x;
  addr_word_u          y;
  logic [7:0]          sp;

  logic [NIBBLE_W-1:0] data_q;
  logic [NIBBLE_W-1:0] xfer_q;
  logic [NIBBLE_W-1:0] src_val;
  addr_word_u          x_wr;
  addr_word_u          y_wr;
  logic [7:0]          sp_wr;
  reg_type             mem_loc;
  logic                need_mem;
  logic                ack_gap;
  logic                write_fire;

  // Page stays put, only the low byte counts
  function automatic addr_word_u inc_ptr(addr_word_u p);
    addr_word_u r;
    r.flat = {p.nib.page, p.flat[7:0] + 8'd1};
    return r;
  endfunction

  assign src_mem    = is_mem_loc(src_q);
  assign dst_mem    = is_mem_loc(dst_q);
  assign mem_done   = bus.ack;
  assign write_fire = (cycle == CYCLE_REG_WRITE) && (!dst_mem || bus.ack);
  assign xfer_data  = xfer_q;

  always_comb begin
    case (src_q)
      REG_A:     src_val = a;
      REG_B:     src_val = b;
      REG_TEMPA: src_val = temp_a;
      REG_TEMPB: src_val = temp_b;
      REG_XL:    src_val = x.nib.lo;
      REG_XH:    src_val = x.nib.hi;
      REG_XP:    src_val = x.nib.page;
      REG_YL:    src_val = y.nib.lo;
      REG_YH:    src_val = y.nib.hi;
      REG_YP:    src_val = y.nib.page;
      REG_SPL:   src_val = sp[3:0];
      REG_SPH:   src_val = sp[7:4];
      REG_IMM:   src_val = immed_q;
      REG_ALU:   src_val = alu_q;
      default:   src_val = '0;
    endcase
  end

  // Pointer values after the destination write, before post-increment
  always_comb begin
    x_wr  = x;
    y_wr  = y;
    sp_wr = sp;
    case (dst_q)
      REG_XL:  x_wr.nib.lo   = data_q;
      REG_XH:  x_wr.nib.hi   = data_q;
      REG_XP:  x_wr.nib.page = data_q;
      REG_YL:  y_wr.nib.lo   = data_q;
      REG_YH:  y_wr.nib.hi   = data_q;
      REG_YP:  y_wr.nib.page = data_q;
      REG_SPL: sp_wr[3:0]    = data_q;
      REG_SPH: sp_wr[7:4]    = data_q;
      default: ;
    endcase
  end

  // ---------------------------------------------------------------------------
  // Wishbone master
  // ---------------------------------------------------------------------------
  assign mem_loc  = (cycle == CYCLE_REG_WRITE) ? dst_q : src_q;
  assign need_mem = ((cycle == CYCLE_REG_FETCH) && src_mem) ||
                    ((cycle == CYCLE_REG_WRITE) && dst_mem);

  // One idle cycle after every ack
  assign bus.cyc   = need_mem && !ack_gap;
  assign bus.stb   = need_mem && !ack_gap;
  assign bus.we    = (cycle == CYCLE_REG_WRITE);
  assign bus.dat_w = data_q;

  always_comb begin
    case (mem_loc)
      REG_MX:  bus.adr = x.flat;
      REG_MY:  bus.adr = y.flat;
      REG_MSP: bus.adr = {{(ADDR_W-8){1'b0}}, sp};
      REG_MN:  bus.adr = {{(ADDR_W-NIBBLE_W){1'b0}}, immed_q};
      default: bus.adr = '0;
    endcase
  end

  // ---------------------------------------------------------------------------
  // Capture, fetch latch and destination write
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      src_q   <= REG_A;
      dst_q   <= REG_A;
      inc_q   <= REG_NONE;
      immed_q <= '0;
      alu_q   <= '0;
      a       <= '0;
      b       <= '0;
      temp_a  <= '0;
      temp_b  <= '0;
      x       <= '0;
      y       <= '0;
      sp      <= '0;
      data_q  <= '0;
      xfer_q  <= '0;
      ack_gap <= 1'b0;
    end else begin
      ack_gap <= bus.ack;
      if (capture) begin
        src_q   <= src;
        dst_q   <= dst;
        inc_q   <= inc;
        immed_q <= immed;
        alu_q   <= alu;
      end
      if (cycle == CYCLE_REG_FETCH) begin
        data_q <= src_mem ? bus.dat_r : src_val;
      end
      if (write_fire) begin
        xfer_q <= data_q;
        case (dst_q)
          REG_A:     a      <= data_q;
          REG_B:     b      <= data_q;
          REG_TEMPA: temp_a <= data_q;
          REG_TEMPB: temp_b <= data_q;
          default: ;
        endcase
        x  <= (inc_q == REG_XHL) ? inc_ptr(x_wr) : x_wr;
        y  <= (inc_q == REG_YHL) ? inc_ptr(y_wr) : y_wr;
        sp <= (inc_q == REG_SP) ? sp_wr + 8'd1 : sp_wr;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/microcycle_ctrl.sv
`default_nettype none

module microcycle_ctrl
  import cpu_types_pkg::*;
(
  input  logic           clk,
  input  logic           arst_n,
  input  logic           start,
  input  logic           src_mem,
  input  logic           dst_mem,
  input  logic           mem_done,
  output microcode_cycle cycle,
  output logic           busy,
  output logic           done
);

  logic fetch_end;
  logic write_end;

  // A phase with a memory operand waits for the bus ack
  assign fetch_end = !src_mem || mem_done;
  assign write_end = !dst_mem || mem_done;

  assign busy = (cycle != CYCLE_NONE);

  // ---------------------------------------------------------------------------
  // Transfer sequencer
  // ---------------------------------------------------------------------------
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      cycle <= CYCLE_NONE;
      done  <= 1'b0;
    end else begin
      done <= 1'b0;
      case (cycle)
        CYCLE_NONE: begin
          if (start) begin
            cycle <= CYCLE_REG_FETCH;
          end
        end
        CYCLE_REG_FETCH: begin
          if (fetch_end) begin
            cycle <= CYCLE_REG_WRITE;
          end
        end
        CYCLE_REG_WRITE: begin
          if (write_end) begin
            cycle <= CYCLE_NONE;
            done  <= 1'b1;
          end
        end
        default: begin
          cycle <= CYCLE_NONE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: hw/data_bus_if.sv
`default_nettype none

// Wishbone classic, single outstanding cycle
interface data_bus_if
  import mem_pkg::*;
();

  logic                cyc;
  logic                stb;
  logic                we;
  logic [ADDR_W-1:0]   adr;
  logic [NIBBLE_W-1:0] dat_w;
  logic [NIBBLE_W-1:0] dat_r;
  logic                ack;

  modport master (
    output cyc, stb, we, adr, dat_w,
    input  dat_r, ack
  );

  modport slave (
    input  cyc, stb, we, adr, dat_w,
    output dat_r, ack
  );

endinterface

`default_nettype wire

// File: hw/cpu_types_pkg.sv
`default_nettype none

package cpu_types_pkg;

  // ---------------------------------------------------------------------------
  // Bus locations for one nibble transfer
  // ---------------------------------------------------------------------------
  typedef enum logic [4:0] {
    REG_A,
    REG_B,
    REG_TEMPA,
    REG_TEMPB,
    REG_XL,
    REG_XH,
    REG_XP,
    REG_YL,
    REG_YH,
    REG_YP,
    REG_SPL,
    REG_SPH,
    // Sources only
    REG_IMM,
    REG_ALU,
    // Data memory through a pointer or the immediate
    REG_MX,
    REG_MY,
    REG_MSP,
    REG_MN
  } reg_type;

  typedef enum logic [1:0] {
    REG_NONE,
    REG_XHL,
    REG_YHL,
    REG_SP
  } reg_inc_type;

  typedef enum logic [1:0] {
    CYCLE_NONE,
    CYCLE_REG_FETCH,
    CYCLE_REG_WRITE
  } microcode_cycle;

  function automatic logic is_mem_loc(reg_type loc);
    return loc inside {REG_MX, REG_MY, REG_MSP, REG_MN};
  endfunction

endpackage

`default_nettype wire

// File: hw/mem_pkg.sv
`default_nettype none

package mem_pkg;

  localparam int NIBBLE_W = 4;
  localparam int ADDR_W   = 12;

  // Pointer split into its three nibbles, page on top
  typedef struct packed {
    logic [NIBBLE_W-1:0] page;
    logic [NIBBLE_W-1:0] hi;
    logic [NIBBLE_W-1:0] lo;
  } addr_nib_t;

  // ---------------------------------------------------------------------------
  // One 12-bit pointer word, seen flat by the memory bus
  // and by nibble from the register side
  // ---------------------------------------------------------------------------
  typedef union packed {
    logic [ADDR_W-1:0] flat;
    addr_nib_t         nib;
  } addr_word_u;

endpackage

`default_nettype wire
